// File: logic/ahb_sram_settings.svh
// Bus width, SRAM depth and SRAM wait-state definitions
`ifndef AHB_SRAM_SETTINGS_SVH
`define AHB_SRAM_SETTINGS_SVH

// ----------------------------------------
// AHB bus widths
// ----------------------------------------
`define AHB_ADDR_W 32        // HADDR bits
`define AHB_DATA_W 32        // HWDATA / HRDATA bits

// ----------------------------------------
// Shared SRAM
// ----------------------------------------
// Word count, byte addresses at or above 4x this give ERROR
`define SRAM_DEPTH 64

// Low HREADYOUT cycles before an OKAY data phase completes
// Zero gives single-cycle transfers
`define SRAM_WAIT_STATES 1

`endif

// File: logic/ahb_sram_pkg.sv
// Transfer type, response and arbiter state enums for the two-port SRAM
package ahb_sram_pkg;

  // HTRANS encoding, SEQ handled like NONSEQ downstream
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,     // No transfer
    TRN_BUSY   = 2'b01,     // Master busy, ignored
    TRN_NONSEQ = 2'b10,     // Single or first beat
    TRN_SEQ    = 2'b11      // Later beat
  } htrans_t;

  // HRESP, only two responses ever produced
  typedef enum logic {
    RSP_OKAY  = 1'b0,
    RSP_ERROR = 1'b1
  } hresp_t;

  // Round-robin memory of the last winner
  // Reset value ARB_LAST_P1 lets port 0 win first
  typedef enum logic {
    ARB_LAST_P0 = 1'b0,
    ARB_LAST_P1 = 1'b1
  } arb_state_t;

endpackage

// File: logic/ahb_input_stage.sv
// AHB input stage: holding register, pending flag, request line, path mux, port response
`timescale 1ns/1ps
`include "ahb_sram_settings.svh"

module ahb_input_stage (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  // Master address phase
  input  logic                   hsel,
  input  logic [`AHB_ADDR_W-1:0] haddr,
  input  ahb_sram_pkg::htrans_t  htrans,
  input  logic                   hwrite,
  input  logic                   hready,      // Port HREADY, master loops back hreadyout
  // From output stage
  input  logic                   active,      // Grant for this cycle
  input  logic                   readyout,    // Shared slave HREADYOUT
  input  ahb_sram_pkg::hresp_t   resp,        // Shared slave HRESP
  // Port response to master
  output logic                   hreadyout,
  output ahb_sram_pkg::hresp_t   hresp,
  // Address phase towards output stage
  output logic                   sel_ip,
  output logic [`AHB_ADDR_W-1:0] addr_ip,
  output ahb_sram_pkg::htrans_t  trans_ip,
  output logic                   write_ip,
  output logic                   held_tran    // Request to arbiter
);

  logic                   addr_valid;     // NONSEQ/SEQ to this port
  logic                   load_reg;       // Accepted address phase
  logic                   pend_tran;      // Next pending state
  logic                   pend_tran_reg;  // Transfer waiting in holding reg
  logic                   data_valid;     // Port is in a data phase
  logic [`AHB_ADDR_W-1:0] reg_addr;
  ahb_sram_pkg::htrans_t  reg_trans;
  logic                   reg_write;

  // ----------------------------------------
  // Holding register
  // ----------------------------------------
  assign addr_valid = hsel & htrans[1];   // IDLE and BUSY drop out here
  assign load_reg   = addr_valid & hready;

  // Captures every accepted transfer, used only if not granted
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_addr  <= haddr;
      reg_trans <= htrans;
      reg_write <= hwrite;
    end
  end

  // Data-phase flag follows the port's own HREADY
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (hready)
      data_valid <= addr_valid;
  end

  // ----------------------------------------
  // Pending flag and request
  // ----------------------------------------
  // Set on a load without grant, cleared once the held copy reaches the slave
  always_comb
  begin
    if (load_reg && !active)
      pend_tran = 1'b1;
    else if (active && readyout)
      pend_tran = 1'b0;
    else
      pend_tran = pend_tran_reg;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran_reg <= 1'b0;
    else
      pend_tran_reg <= pend_tran;
  end

  assign held_tran = load_reg | pend_tran_reg;   // Direct or held request

  // Direct path, or held copy forced to selected NONSEQ
  always_comb
  begin
    if (!pend_tran_reg)
    begin
      sel_ip   = hsel;
      addr_ip  = haddr;
      trans_ip = htrans;
      write_ip = hwrite;
    end
    else
    begin
      sel_ip   = 1'b1;
      addr_ip  = reg_addr;
      trans_ip = ahb_sram_pkg::TRN_NONSEQ;   // SEQ restarts as NONSEQ
      write_ip = reg_write;
    end
  end

  // ----------------------------------------
  // Port response
  // ----------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      hreadyout = 1'b1;                      // Idle port always ready
      hresp     = ahb_sram_pkg::RSP_OKAY;
    end
    else if (pend_tran_reg)
    begin
      hreadyout = 1'b0;                      // Stall until slave takes it
      hresp     = ahb_sram_pkg::RSP_OKAY;
    end
    else
    begin
      hreadyout = readyout;                  // Own data phase on the slave
      hresp     = resp;
    end
  end

  // Held transfer was a real one and goes out selected as NONSEQ
  a_held_nonseq : assert property (@(posedge HCLK) disable iff (!HRESETn)
    pend_tran_reg |-> sel_ip && trans_ip == ahb_sram_pkg::TRN_NONSEQ &&
                      reg_trans inside {ahb_sram_pkg::TRN_NONSEQ, ahb_sram_pkg::TRN_SEQ});

endmodule

// File: logic/ahb_output_stage.sv
// AHB output stage: round-robin arbiter, address mux, data-phase owner and write-data mux
`timescale 1ns/1ps
`include "ahb_sram_settings.svh"

module ahb_output_stage (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  // Port 0 address phase
  input  logic                   p0_held_tran,
  input  logic                   p0_sel,
  input  logic [`AHB_ADDR_W-1:0] p0_addr,
  input  ahb_sram_pkg::htrans_t  p0_trans,
  input  logic                   p0_write,
  input  logic [`AHB_DATA_W-1:0] p0_hwdata,
  // Port 1 address phase
  input  logic                   p1_held_tran,
  input  logic                   p1_sel,
  input  logic [`AHB_ADDR_W-1:0] p1_addr,
  input  ahb_sram_pkg::htrans_t  p1_trans,
  input  logic                   p1_write,
  input  logic [`AHB_DATA_W-1:0] p1_hwdata,
  // Grants
  output logic                   p0_active,
  output logic                   p1_active,
  // Shared slave response
  input  logic                   s_hreadyout,
  input  ahb_sram_pkg::hresp_t   s_hresp,
  // Shared slave bus
  output logic                   s_hsel,
  output logic [`AHB_ADDR_W-1:0] s_haddr,
  output ahb_sram_pkg::htrans_t  s_htrans,
  output logic                   s_hwrite,
  output logic [`AHB_DATA_W-1:0] s_hwdata,
  output logic                   s_hready
);

  ahb_sram_pkg::arb_state_t last_grant;   // Port granted last
  logic                     dp_valid;     // Slave in a data phase
  logic                     dp_owner;     // 1 when port 1 owns it

  assign s_hready = s_hreadyout;          // Single slave, HREADY from its own output

  // ----------------------------------------
  // Round-robin arbiter
  // ----------------------------------------
  always_comb
  begin
    p0_active = 1'b0;
    p1_active = 1'b0;
    if (s_hready)                          // Grant only when slave can accept
    begin
      if (p0_held_tran && p1_held_tran)
      begin
        if (last_grant == ahb_sram_pkg::ARB_LAST_P1)
          p0_active = 1'b1;
        else
          p1_active = 1'b1;
      end
      else
      begin
        p0_active = p0_held_tran;          // At most one requesting
        p1_active = p1_held_tran;
      end
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      last_grant <= ahb_sram_pkg::ARB_LAST_P1;   // Port 0 first
    else if (p0_active)
      last_grant <= ahb_sram_pkg::ARB_LAST_P0;
    else if (p1_active)
      last_grant <= ahb_sram_pkg::ARB_LAST_P1;
  end

  // ----------------------------------------
  // Address phase mux
  // ----------------------------------------
  always_comb
  begin
    s_hsel   = 1'b0;                       // Default IDLE, deselected
    s_haddr  = '0;
    s_htrans = ahb_sram_pkg::TRN_IDLE;
    s_hwrite = 1'b0;
    if (p0_active)
    begin
      s_hsel   = p0_sel;
      s_haddr  = p0_addr;
      s_htrans = p0_trans;
      s_hwrite = p0_write;
    end
    else if (p1_active)
    begin
      s_hsel   = p1_sel;
      s_haddr  = p1_addr;
      s_htrans = p1_trans;
      s_hwrite = p1_write;
    end
  end

  // Data-phase owner, moves with the shared HREADY
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      dp_valid <= 1'b0;
      dp_owner <= 1'b0;
    end
    else if (s_hready)
    begin
      dp_valid <= p0_active | p1_active;
      dp_owner <= p1_active;
    end
  end

  // Write data from the owning master
  assign s_hwdata = !dp_valid ? '0 : (dp_owner ? p1_hwdata : p0_hwdata);

  a_one_grant : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(p0_active && p1_active));

  // Slave errors only inside a data phase this stage started
  a_err_owned : assert property (@(posedge HCLK) disable iff (!HRESETn)
    s_hresp == ahb_sram_pkg::RSP_ERROR |-> dp_valid);

endmodule

// File: logic/ahb_sram_slave.sv
// Word-wide AHB SRAM slave with fixed wait states and two-cycle ERROR
`timescale 1ns/1ps
`include "ahb_sram_settings.svh"

module ahb_sram_slave (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   hsel,
  input  logic [`AHB_ADDR_W-1:0] haddr,
  input  ahb_sram_pkg::htrans_t  htrans,
  input  logic                   hwrite,
  input  logic [`AHB_DATA_W-1:0] hwdata,
  input  logic                   hready,
  output logic                   hreadyout,
  output ahb_sram_pkg::hresp_t   hresp,
  output logic [`AHB_DATA_W-1:0] hrdata
);

  localparam int IDX_W = $clog2(`SRAM_DEPTH);              // Word index bits
  localparam int CNT_W = $clog2(`SRAM_WAIT_STATES + 2);
  localparam logic [CNT_W-1:0] WAIT_INIT = CNT_W'(`SRAM_WAIT_STATES);
  localparam logic [`AHB_ADDR_W-1:0] ADDR_LIMIT = `SRAM_DEPTH * 4;   // First bad byte

  logic [`AHB_DATA_W-1:0] mem [0:`SRAM_DEPTH-1];
  logic                   addr_valid;
  logic                   out_of_range;
  logic                   dp_active;     // Data phase in progress
  logic                   dp_err;        // Data phase answers ERROR
  logic                   err_late;      // Second ERROR cycle
  logic                   dp_write;
  logic [IDX_W-1:0]       dp_addr;
  logic [CNT_W-1:0]       wait_cnt;      // Remaining low cycles

  assign addr_valid   = hsel & htrans[1];
  assign out_of_range = haddr >= ADDR_LIMIT;

  // ----------------------------------------
  // Data phase control
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      dp_active <= 1'b0;
      dp_err    <= 1'b0;
      err_late  <= 1'b0;
      wait_cnt  <= '0;
    end
    else if (hready)
    begin                                  // New address phase taken
      dp_active <= addr_valid;
      dp_err    <= addr_valid & out_of_range;
      err_late  <= 1'b0;
      wait_cnt  <= WAIT_INIT;
    end
    else
    begin
      err_late <= dp_err;
      if (wait_cnt != '0)
        wait_cnt <= wait_cnt - 1'b1;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (hready && addr_valid)
    begin
      dp_addr  <= haddr[IDX_W+1:2];        // Byte lanes ignored
      dp_write <= hwrite;
    end
  end

  assign hreadyout = !dp_active || (dp_err ? err_late : (wait_cnt == '0));
  assign hresp     = (dp_active && dp_err) ? ahb_sram_pkg::RSP_ERROR
                                           : ahb_sram_pkg::RSP_OKAY;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (dp_active && dp_write && !dp_err && hreadyout)
      mem[dp_addr] <= hwdata;              // Last cycle of the data phase
  end

  assign hrdata = (dp_active && !dp_write && !dp_err) ? mem[dp_addr] : '0;

  // ERROR starts only right after an accepted address phase
  a_err_in_dp : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(hresp == ahb_sram_pkg::RSP_ERROR) |-> $past(hready && addr_valid));

  // Two-cycle ERROR, low then high
  a_err_shape : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hresp == ahb_sram_pkg::RSP_ERROR && !hreadyout)
      |=> (hresp == ahb_sram_pkg::RSP_ERROR && hreadyout));

endmodule

// File: logic/ahb_two_port_sram.sv
// Two-port AHB SRAM top: two input stages, output stage and SRAM slave
`timescale 1ns/1ps
`include "ahb_sram_settings.svh"

module ahb_two_port_sram (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  // ----------------------------------------
  // Master port 0
  input  logic                   p0_hsel,
  input  logic [`AHB_ADDR_W-1:0] p0_haddr,
  input  ahb_sram_pkg::htrans_t  p0_htrans,
  input  logic                   p0_hwrite,
  input  logic [`AHB_DATA_W-1:0] p0_hwdata,
  input  logic                   p0_hready,
  output logic                   p0_hreadyout,
  output ahb_sram_pkg::hresp_t   p0_hresp,
  output logic [`AHB_DATA_W-1:0] p0_hrdata,
  // ----------------------------------------
  // Master port 1
  input  logic                   p1_hsel,
  input  logic [`AHB_ADDR_W-1:0] p1_haddr,
  input  ahb_sram_pkg::htrans_t  p1_htrans,
  input  logic                   p1_hwrite,
  input  logic [`AHB_DATA_W-1:0] p1_hwdata,
  input  logic                   p1_hready,
  output logic                   p1_hreadyout,
  output ahb_sram_pkg::hresp_t   p1_hresp,
  output logic [`AHB_DATA_W-1:0] p1_hrdata
);

  // Input stage to output stage
  logic p0_sel, p0_write, p0_held_tran, p0_active;
  logic p1_sel, p1_write, p1_held_tran, p1_active;
  logic [`AHB_ADDR_W-1:0] p0_addr, p1_addr;
  ahb_sram_pkg::htrans_t  p0_trans, p1_trans;

  // Shared SRAM bus
  logic                   s_hsel, s_hwrite, s_hready, s_hreadyout;
  logic [`AHB_ADDR_W-1:0] s_haddr;
  logic [`AHB_DATA_W-1:0] s_hwdata, s_hrdata;
  ahb_sram_pkg::htrans_t  s_htrans;
  ahb_sram_pkg::hresp_t   s_hresp;

  ahb_input_stage u_p0_input_stage (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(p0_hsel), .haddr(p0_haddr), .htrans(p0_htrans), .hwrite(p0_hwrite),
    .hready(p0_hready), .active(p0_active), .readyout(s_hreadyout), .resp(s_hresp),
    .hreadyout(p0_hreadyout), .hresp(p0_hresp),
    .sel_ip(p0_sel), .addr_ip(p0_addr), .trans_ip(p0_trans), .write_ip(p0_write),
    .held_tran(p0_held_tran));

  ahb_input_stage u_p1_input_stage (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(p1_hsel), .haddr(p1_haddr), .htrans(p1_htrans), .hwrite(p1_hwrite),
    .hready(p1_hready), .active(p1_active), .readyout(s_hreadyout), .resp(s_hresp),
    .hreadyout(p1_hreadyout), .hresp(p1_hresp),
    .sel_ip(p1_sel), .addr_ip(p1_addr), .trans_ip(p1_trans), .write_ip(p1_write),
    .held_tran(p1_held_tran));

  ahb_output_stage u_output_stage (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .p0_held_tran(p0_held_tran), .p0_sel(p0_sel), .p0_addr(p0_addr),
    .p0_trans(p0_trans), .p0_write(p0_write), .p0_hwdata(p0_hwdata),
    .p1_held_tran(p1_held_tran), .p1_sel(p1_sel), .p1_addr(p1_addr),
    .p1_trans(p1_trans), .p1_write(p1_write), .p1_hwdata(p1_hwdata),
    .p0_active(p0_active), .p1_active(p1_active),
    .s_hreadyout(s_hreadyout), .s_hresp(s_hresp),
    .s_hsel(s_hsel), .s_haddr(s_haddr), .s_htrans(s_htrans), .s_hwrite(s_hwrite),
    .s_hwdata(s_hwdata), .s_hready(s_hready));

  ahb_sram_slave u_sram (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(s_hsel), .haddr(s_haddr), .htrans(s_htrans), .hwrite(s_hwrite),
    .hwdata(s_hwdata), .hready(s_hready),
    .hreadyout(s_hreadyout), .hresp(s_hresp), .hrdata(s_hrdata));

  assign p0_hrdata = s_hrdata;   // Read data broadcast to both ports
  assign p1_hrdata = s_hrdata;

endmodule

// File: verification/tb_ahb_two_port_sram.sv
// Two-port AHB SRAM testbench with clock, reset, stimulus table, master drivers and checks
`timescale 1ns/1ps
`include "ahb_sram_settings.svh"

module tb_ahb_two_port_sram;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_ENTRIES  = 16;
  localparam int ENTRY_BOUND  = (`SRAM_WAIT_STATES + 2) * 3;   // Worst cycles per entry

  logic                   HCLK = 1'b0;
  logic                   HRESETn;
  logic                   p0_hsel, p0_hwrite, p0_hready, p0_hreadyout;
  logic                   p1_hsel, p1_hwrite, p1_hready, p1_hreadyout;
  logic [`AHB_ADDR_W-1:0] p0_haddr, p1_haddr;
  logic [`AHB_DATA_W-1:0] p0_hwdata, p1_hwdata, p0_hrdata, p1_hrdata;
  ahb_sram_pkg::htrans_t  p0_htrans, p1_htrans;
  ahb_sram_pkg::hresp_t   p0_hresp, p1_hresp;

  // ----------------------------------------
  // Stimulus table with one column per port
  // ----------------------------------------
  logic [1:0]             t_mask     [0:MAX_ENTRIES-1];        // 0 means idle check
  logic                   t_write    [0:MAX_ENTRIES-1];
  logic [`AHB_ADDR_W-1:0] t_addr     [0:MAX_ENTRIES-1][0:1];
  logic [`AHB_DATA_W-1:0] t_wdata    [0:MAX_ENTRIES-1][0:1];
  logic [`AHB_DATA_W-1:0] t_exp_data [0:MAX_ENTRIES-1][0:1];
  ahb_sram_pkg::hresp_t   t_exp_resp [0:MAX_ENTRIES-1][0:1];
  int                     num_entries = 0;

  logic [`AHB_DATA_W-1:0] model_mem [0:`SRAM_DEPTH-1];        // Scoreboard memory
  logic [31:0]            lfsr_state = 32'h11e0;
  int                     res_lat   [0:1];                    // Data-phase cycles seen
  ahb_sram_pkg::hresp_t   res_resp  [0:1];
  logic [`AHB_DATA_W-1:0] res_rdata [0:1];
  int                     cycle_count = 0;
  int                     cycle_limit = 0;

  ahb_two_port_sram u_ahb_two_port_sram (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .p0_hsel(p0_hsel), .p0_haddr(p0_haddr), .p0_htrans(p0_htrans), .p0_hwrite(p0_hwrite),
    .p0_hwdata(p0_hwdata), .p0_hready(p0_hready), .p0_hreadyout(p0_hreadyout),
    .p0_hresp(p0_hresp), .p0_hrdata(p0_hrdata),
    .p1_hsel(p1_hsel), .p1_haddr(p1_haddr), .p1_htrans(p1_htrans), .p1_hwrite(p1_hwrite),
    .p1_hwdata(p1_hwdata), .p1_hready(p1_hready), .p1_hreadyout(p1_hreadyout),
    .p1_hresp(p1_hresp), .p1_hrdata(p1_hrdata));

  assign p0_hready = p0_hreadyout;   // Masters loop back their own ready
  assign p1_hready = p1_hreadyout;

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  // Run limit from the table length
  always @(posedge HCLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("TIMEOUT: no result within %0d clock cycles", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped by timeout");
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++)
    begin
      w[i]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic in_range(input logic [31:0] addr);
    return addr < 32'(4 * `SRAM_DEPTH);               // Byte address against word count
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % `SRAM_DEPTH);           // Aliased word of any address
  endfunction

  // OKAY after the wait states and ERROR in two cycles
  function automatic int expected_latency(input ahb_sram_pkg::hresp_t resp);
    return (resp == ahb_sram_pkg::RSP_ERROR) ? 2 : `SRAM_WAIT_STATES + 1;
  endfunction

  function automatic logic port_ready(input int port);
    return (port == 0) ? p0_hreadyout : p1_hreadyout;
  endfunction

  task automatic drive_addr(input int port, input logic sel, input logic [31:0] addr,
                            input ahb_sram_pkg::htrans_t trans, input logic write);
    if (port == 0)
    begin
      p0_hsel   = sel;
      p0_haddr  = addr;
      p0_htrans = trans;
      p0_hwrite = write;
    end
    else
    begin
      p1_hsel   = sel;
      p1_haddr  = addr;
      p1_htrans = trans;
      p1_hwrite = write;
    end
  endtask

  task automatic drive_wdata(input int port, input logic [31:0] data);
    if (port == 0)
      p0_hwdata = data;
    else
      p1_hwdata = data;
  endtask

  // Table row with expected values from the memory model
  task automatic add_entry(input logic [1:0] mask, input logic write,
                           input logic [31:0] a0, input logic [31:0] a1);
    logic [31:0] addr;
    logic [31:0] wdata;
    int          p;
    t_mask[num_entries]  = mask;
    t_write[num_entries] = write;
    for (p = 0; p < 2; p++)
    begin
      addr  = (p == 0) ? a0 : a1;
      wdata = '0;
      if (mask[p] && write)
        random_word(wdata);
      t_addr[num_entries][p]     = addr;
      t_wdata[num_entries][p]    = wdata;
      t_exp_resp[num_entries][p] = in_range(addr) ? ahb_sram_pkg::RSP_OKAY
                                                  : ahb_sram_pkg::RSP_ERROR;
      t_exp_data[num_entries][p] = in_range(addr) ? model_mem[word_index(addr)] : '0;
      if (mask[p] && write && in_range(addr))
        model_mem[word_index(addr)] = wdata;          // Errors leave memory alone
    end
    num_entries++;
  endtask

  task automatic build_table();
    add_entry(2'b01, 1'b1, 32'h0000_0000, 32'h0);            // Write then read on p0
    add_entry(2'b01, 1'b0, 32'h0000_0000, 32'h0);
    add_entry(2'b10, 1'b1, 32'h0, 32'h0000_0010);            // p1 writes and p0 reads
    add_entry(2'b01, 1'b0, 32'h0000_0010, 32'h0);
    add_entry(2'b11, 1'b1, 32'h0000_0020, 32'h0000_0024);    // Contended writes
    add_entry(2'b01, 1'b0, 32'h0000_0020, 32'h0);
    add_entry(2'b10, 1'b0, 32'h0, 32'h0000_0024);
    add_entry(2'b11, 1'b0, 32'h0000_0024, 32'h0000_0020);    // Contended reads
    add_entry(2'b01, 1'b1, 32'h0000_0014, 32'h0);
    add_entry(2'b10, 1'b1, 32'h0, 32'h0000_0114);            // Out of range and aliasing 0x14
    add_entry(2'b01, 1'b0, 32'h0000_0114, 32'h0);
    add_entry(2'b01, 1'b0, 32'h0000_0014, 32'h0);            // Alias untouched
    add_entry(2'b00, 1'b0, 32'h0, 32'h0);                    // Idle ports beside reads of 0x0
    add_entry(2'b11, 1'b1, 32'h0000_00fc, 32'h0000_0200);    // OKAY and ERROR together
    add_entry(2'b10, 1'b0, 32'h0, 32'h0000_00fc);
    add_entry(2'b10, 1'b0, 32'h0, 32'h0000_0000);
  endtask

  // ----------------------------------------
  // Master driver for one transfer on one port
  // ----------------------------------------
  task automatic master_transfer(input int port, input int idx);
    int lat;
    @(negedge HCLK);
    drive_addr(port, 1'b1, t_addr[idx][port], ahb_sram_pkg::TRN_NONSEQ, t_write[idx]);
    while (!port_ready(port))                 // Address phase waits for HREADY
      @(negedge HCLK);
    @(negedge HCLK);                          // Data phase starts
    drive_addr(port, 1'b0, '0, ahb_sram_pkg::TRN_IDLE, 1'b0);
    drive_wdata(port, t_wdata[idx][port]);
    lat = 1;
    while (!port_ready(port))
    begin
      lat++;
      @(negedge HCLK);
    end
    res_lat[port]   = lat;                    // Response stable until the edge
    res_resp[port]  = (port == 0) ? p0_hresp : p1_hresp;
    res_rdata[port] = (port == 0) ? p0_hrdata : p1_hrdata;
  endtask

  // Idle stimulus on one port while the other port's read holds the slave in wait
  task automatic idle_beside_read(input int idx, input int port, input logic sel,
                                  input ahb_sram_pkg::htrans_t trans);
    int busy;
    busy = 1 - port;
    fork
      master_transfer(busy, idx);
      begin
        @(negedge HCLK);
        drive_addr(port, sel, 32'h0000_0008, trans, 1'b1);
        @(negedge HCLK);                      // Other port in its wait state
        check_value($sformatf("p%0d_hreadyout", port), 32'(port_ready(port)), 32'h1);
        check_value($sformatf("p%0d_hresp", port),
                    32'((port == 0) ? p0_hresp : p1_hresp),
                    32'(ahb_sram_pkg::RSP_OKAY));
        drive_addr(port, 1'b0, '0, ahb_sram_pkg::TRN_IDLE, 1'b0);
      end
    join
    check_value($sformatf("p%0d_hresp", busy), 32'(res_resp[busy]),
                32'(t_exp_resp[idx][busy]));
    check_value($sformatf("p%0d_hrdata", busy), res_rdata[busy], t_exp_data[idx][busy]);
  endtask

  task automatic run_entry(input int idx);
    int p;
    int lat_sum;
    int lat_max;
    lat_sum = 0;
    lat_max = 0;
    if (t_mask[idx] == 2'b00)
    begin
      idle_beside_read(idx, 0, 1'b1, ahb_sram_pkg::TRN_IDLE);     // Selected IDLE on p0
      idle_beside_read(idx, 1, 1'b0, ahb_sram_pkg::TRN_NONSEQ);   // Unselected NONSEQ on p1
    end
    else
    begin
      fork
        begin
          if (t_mask[idx][0])
            master_transfer(0, idx);
        end
        begin
          if (t_mask[idx][1])
            master_transfer(1, idx);
        end
      join
      for (p = 0; p < 2; p++)
      begin
        if (t_mask[idx][p])
        begin
          check_value($sformatf("p%0d_hresp", p), 32'(res_resp[p]),
                      32'(t_exp_resp[idx][p]));
          if (!t_write[idx] && t_exp_resp[idx][p] == ahb_sram_pkg::RSP_OKAY)
            check_value($sformatf("p%0d_hrdata", p), res_rdata[p], t_exp_data[idx][p]);
          lat_sum += expected_latency(t_exp_resp[idx][p]);
          if (res_lat[p] > lat_max)
            lat_max = res_lat[p];
        end
      end
      // Held transfer finishes right after the winner
      check_value($sformatf("entry %0d completion cycles", idx), lat_max, lat_sum);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    HRESETn = 1'b0;
    drive_addr(0, 1'b0, '0, ahb_sram_pkg::TRN_IDLE, 1'b0);
    drive_addr(1, 1'b0, '0, ahb_sram_pkg::TRN_IDLE, 1'b0);
    drive_wdata(0, '0);
    drive_wdata(1, '0);
    build_table();
    cycle_limit = RESET_CYCLES + num_entries * ENTRY_BOUND;
    repeat (RESET_CYCLES) @(negedge HCLK);
    HRESETn = 1'b1;
    for (int i = 0; i < num_entries; i++)
      run_entry(i);
    @(negedge HCLK);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: flist.f
+incdir+logic
logic/ahb_sram_pkg.sv
logic/ahb_input_stage.sv
logic/ahb_output_stage.sv
logic/ahb_sram_slave.sv
logic/ahb_two_port_sram.sv
verification/tb_ahb_two_port_sram.sv

// File: Makefile
# Verilator build and run of the two-port AHB SRAM testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module tb_ahb_two_port_sram -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
